// File: rtl/ahb_ic_config.svh
// AHB-Lite multi-layer interconnect configuration
// bus geometry, slave address map and SRAM depth
// shared by the package, the master ports, the SRAM slaves and the top

`ifndef AHB_IC_CONFIG_SVH
`define AHB_IC_CONFIG_SVH

// port counts
`define AHB_IC_MASTERS     3
`define AHB_IC_SLAVES      2

// bus widths
`define AHB_IC_AW          32
`define AHB_IC_DW          32

// slave windows, aligned to the window size
`define AHB_IC_SLV_BASE0   32'h0000_0000
`define AHB_IC_SLV_BASE1   32'h0000_1000
`define AHB_IC_SLV_SIZE    32'h0000_1000   // 4 KiB each, 0x2000 and up is unmapped

// words per SRAM slave
`define AHB_IC_SRAM_WORDS  1024

`endif

// File: rtl/ahb_ic_pkg.sv
// AHB-Lite interconnect types
// transfer encodings and the request / response bundles carried
// between master ports, slave ports and slaves

`default_nettype none

`include "ahb_ic_config.svh"

package ahb_ic_pkg;

  // HTRANS encoding
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_e;

  // HRESP, AHB-Lite only uses one bit
  localparam logic RESP_OKAY  = 1'b0;
  localparam logic RESP_ERROR = 1'b1;

  typedef logic [`AHB_IC_AW-1:0]      addr_t;
  typedef logic [`AHB_IC_DW-1:0]      data_t;
  typedef logic [2:0]                 prio_t;     // larger value wins
  typedef logic [`AHB_IC_MASTERS-1:0] mst_vec_t;  // one bit per master

  // address phase plus write data, 80 bits
  typedef struct packed {
    logic    sel;       // HSEL
    addr_t   addr;      // HADDR
    logic    write;     // HWRITE
    logic [2:0] size;   // HSIZE
    logic [2:0] burst;  // HBURST, passed through only
    logic [3:0] prot;   // HPROT, passed through only
    htrans_e trans;     // HTRANS
    logic    mastlock;  // HMASTLOCK
    logic    ready;     // HREADY of the bus seen by the slave
    data_t   wdata;     // HWDATA, data phase
  } ahb_req_t;

  // slave response, 34 bits
  typedef struct packed {
    data_t rdata;       // HRDATA
    logic  ready;       // HREADYOUT
    logic  resp;        // HRESP
  } ahb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/ahb_master_port.sv
// AHB-Lite master port
// decodes the master's address onto slave 0, slave 1 or the default slave,
// stalls the master until the target slave port grants it and returns the
// data-phase response; unmapped accesses get the two-cycle ERROR

`timescale 1ns/10ps
`default_nettype none

`include "ahb_ic_config.svh"

module ahb_master_port (
  input  wire logic                 HCLK,
  input  wire logic                 HRESETn,
  input  ahb_ic_pkg::ahb_req_t      mst_req,                   // from the master
  output ahb_ic_pkg::ahb_rsp_t      mst_rsp,                   // to the master
  output ahb_ic_pkg::ahb_req_t      req_to_slv [`AHB_IC_SLAVES],
  output logic                      can_switch,
  input  wire logic [`AHB_IC_SLAVES-1:0] granted,              // one bit per slave port
  input  ahb_ic_pkg::ahb_rsp_t      slv_rsp [`AHB_IC_SLAVES]
);

  localparam logic [1:0] TGT_S0  = 2'd0;
  localparam logic [1:0] TGT_S1  = 2'd1;
  localparam logic [1:0] TGT_DEF = 2'd2;  // default slave

  logic       ap_valid;   // NONSEQ or SEQ on the master
  logic [1:0] ap_tgt;     // decoded address-phase target
  logic       ap_ok;      // address phase may complete
  logic       dp_valid;   // data phase outstanding
  logic [1:0] dp_tgt;
  logic       err_first;  // first cycle of the ERROR response
  logic       dp_fin;     // data phase result available this cycle
  logic       hready;
  logic       hold_valid; // result captured during a grant stall
  ahb_ic_pkg::data_t hold_rdata;
  logic       hold_resp;
  ahb_ic_pkg::data_t live_rdata;
  logic       live_resp;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////
  assign ap_valid = (mst_req.trans == ahb_ic_pkg::NONSEQ) ||
                    (mst_req.trans == ahb_ic_pkg::SEQ);

  always_comb begin
    if ((mst_req.addr & ~(`AHB_IC_SLV_SIZE - 1)) == `AHB_IC_SLV_BASE0)
      ap_tgt = TGT_S0;
    else if ((mst_req.addr & ~(`AHB_IC_SLV_SIZE - 1)) == `AHB_IC_SLV_BASE1)
      ap_tgt = TGT_S1;
    else
      ap_tgt = TGT_DEF;
  end

  // default slave takes any address; a real slave needs grant and a free bus
  assign ap_ok = !ap_valid || (ap_tgt == TGT_DEF) ||
                 (granted[ap_tgt[0]] && slv_rsp[ap_tgt[0]].ready);

  assign dp_fin = dp_valid && ((dp_tgt == TGT_DEF) ? !err_first
                                                   : slv_rsp[dp_tgt[0]].ready);

  assign hready = (!dp_valid || dp_fin) && ap_ok;

  // never drop a locked owner mid sequence
  assign can_switch = !(mst_req.mastlock && (ap_valid || dp_valid));

  ////////////////////////////////////////
  // requests toward the slave ports
  ////////////////////////////////////////
  for (genvar s = 0; s < `AHB_IC_SLAVES; s++) begin : g_req
    always_comb begin
      req_to_slv[s]       = mst_req;
      req_to_slv[s].sel   = ap_valid && (ap_tgt == 2'(s));  // only toward the decoded slave
      req_to_slv[s].ready = hready;                         // slave samples on our HREADY
    end
  end

  ////////////////////////////////////////
  // data phase tracking
  ////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid   <= 1'b0;
      dp_tgt     <= TGT_S0;
      err_first  <= 1'b0;
      hold_valid <= 1'b0;
    end else if (hready) begin
      dp_valid   <= ap_valid;
      dp_tgt     <= ap_tgt;
      err_first  <= ap_valid && (ap_tgt == TGT_DEF);
      hold_valid <= 1'b0;                               // held result delivered now
    end else begin
      err_first  <= 1'b0;                               // error goes to its second cycle
      if (dp_fin) begin
        dp_valid   <= 1'b0;                             // slave is done, master still stalled
        hold_valid <= 1'b1;
      end
    end
  end

  // captured result, payload only
  always_ff @(posedge HCLK) begin
    if (!hready && dp_fin) begin
      hold_rdata <= live_rdata;
      hold_resp  <= live_resp;
    end
  end

  ////////////////////////////////////////
  // response to the master
  ////////////////////////////////////////
  assign live_rdata = (dp_tgt == TGT_DEF) ? '0 : slv_rsp[dp_tgt[0]].rdata;
  assign live_resp  = (dp_tgt == TGT_DEF) ? ahb_ic_pkg::RESP_ERROR
                                          : slv_rsp[dp_tgt[0]].resp;

  assign mst_rsp.ready = hready;
  assign mst_rsp.rdata = hold_valid ? hold_rdata : live_rdata;
  assign mst_rsp.resp  = hold_valid ? hold_resp
                       : dp_valid   ? live_resp : ahb_ic_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: rtl/ahb_slave_port.sv
// AHB-Lite slave port
// arbitrates the masters that select this slave: highest priority first,
// round-robin inside one priority level; multiplexes the owner's address
// phase to the slave and its write data one phase later

`timescale 1ns/10ps
`default_nettype none

module ahb_slave_port (
  input  wire logic                HCLK,
  input  wire logic                HRESETn,
  input  ahb_ic_pkg::ahb_req_t     mst_req [$bits(ahb_ic_pkg::mst_vec_t)],
  input  ahb_ic_pkg::prio_t        mst_prio [$bits(ahb_ic_pkg::mst_vec_t)],
  input  ahb_ic_pkg::mst_vec_t     can_switch,
  output ahb_ic_pkg::mst_vec_t     granted_master,
  output ahb_ic_pkg::ahb_req_t     slv_req,
  input  ahb_ic_pkg::ahb_rsp_t     slv_rsp,
  output ahb_ic_pkg::ahb_rsp_t     mst_rsp
);

  localparam int MASTERS = $bits(ahb_ic_pkg::mst_vec_t);
  localparam int LEVELS  = 2 ** $bits(ahb_ic_pkg::prio_t);
  localparam int IDX_W   = $clog2(MASTERS);

  ahb_ic_pkg::mst_vec_t req_sel;          // masters selecting this slave
  ahb_ic_pkg::prio_t    req_lvl;          // highest requested level
  ahb_ic_pkg::mst_vec_t prio_masters;     // requesters at that level
  ahb_ic_pkg::mst_vec_t last_granted;     // last owner at that level
  ahb_ic_pkg::mst_vec_t pending_master;   // next owner
  ahb_ic_pkg::mst_vec_t last_granted_masters [LEVELS];
  logic [IDX_W-1:0]     granted_idx;
  logic [IDX_W-1:0]     granted_idx_dly;  // owner of the data phase
  logic                 can_switch_master;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  function automatic logic [IDX_W-1:0] onehot2int(input ahb_ic_pkg::mst_vec_t vec);
    logic [IDX_W-1:0] idx;
    idx = '0;
    for (int n = 0; n < MASTERS; n++)
      if (vec[n]) idx = IDX_W'(n);
    return idx;
  endfunction

  // first pending master after the last one served, else keep current
  function automatic ahb_ic_pkg::mst_vec_t nxt_master(
    input ahb_ic_pkg::mst_vec_t pend,
    input ahb_ic_pkg::mst_vec_t last,
    input ahb_ic_pkg::mst_vec_t cur
  );
    ahb_ic_pkg::mst_vec_t nxt;
    int offset;
    int idx;
    nxt    = cur;
    offset = int'(onehot2int(last)) + 1;
    for (int n = MASTERS - 1; n >= 0; n--) begin   // lowest distance assigned last
      idx = (n + offset) % MASTERS;
      if (pend[idx]) nxt = ahb_ic_pkg::mst_vec_t'(1) << idx;
    end
    return nxt;
  endfunction

  ////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////
  always_comb begin
    req_lvl = '0;
    for (int m = 0; m < MASTERS; m++) begin
      req_sel[m] = mst_req[m].sel;
      if (mst_req[m].sel && (mst_prio[m] > req_lvl)) req_lvl = mst_prio[m];
    end
    for (int m = 0; m < MASTERS; m++)
      prio_masters[m] = mst_req[m].sel && (mst_prio[m] == req_lvl);
  end

  assign last_granted      = last_granted_masters[req_lvl];
  assign pending_master    = nxt_master(prio_masters, last_granted, granted_master);
  assign granted_idx       = onehot2int(granted_master);
  assign can_switch_master = can_switch[granted_idx];

  // grant moves only on a completed slave cycle
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      granted_master <= ahb_ic_pkg::mst_vec_t'(1);
      for (int l = 0; l < LEVELS; l++)
        last_granted_masters[l] <= ahb_ic_pkg::mst_vec_t'(1);
    end else if (slv_rsp.ready && can_switch_master) begin
      granted_master <= pending_master;
      if (|req_sel) last_granted_masters[req_lvl] <= pending_master;
    end
  end

  // address phase done -> its owner drives HWDATA next
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn)           granted_idx_dly <= '0;
    else if (slv_rsp.ready) granted_idx_dly <= granted_idx;
  end

  ////////////////////////////////////////
  // multiplexers
  ////////////////////////////////////////
  always_comb begin
    slv_req       = mst_req[granted_idx];               // ready is the owner's HREADY
    slv_req.wdata = mst_req[granted_idx_dly].wdata;
  end

  assign mst_rsp = slv_rsp;                             // same response to every master

endmodule

`default_nettype wire

// File: rtl/ahb_sram_slave.sv
// AHB-Lite SRAM slave
// zero-wait writes with byte / halfword / word lanes,
// reads with one wait state, never errors

`timescale 1ns/10ps
`default_nettype none

`include "ahb_ic_config.svh"

module ahb_sram_slave (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,
  input  ahb_ic_pkg::ahb_req_t  slv_req,
  output ahb_ic_pkg::ahb_rsp_t  slv_rsp
);

  localparam int WA = $clog2(`AHB_IC_SRAM_WORDS);
  localparam int NB = `AHB_IC_DW / 8;

  ahb_ic_pkg::data_t mem [`AHB_IC_SRAM_WORDS];

  logic          accept;    // address phase completes
  logic          wr_pend;   // write data phase
  logic          rd_pend;   // read wait state
  logic [WA-1:0] dp_word;
  logic [1:0]    dp_lo;     // byte offset
  logic [2:0]    dp_size;
  logic [NB-1:0] be;
  ahb_ic_pkg::data_t rdata;

  assign accept = slv_req.sel && slv_req.ready && slv_rsp.ready &&
                  ((slv_req.trans == ahb_ic_pkg::NONSEQ) ||
                   (slv_req.trans == ahb_ic_pkg::SEQ));

  ////////////////////////////////////////
  // address phase registers
  ////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_pend <= 1'b0;
      rd_pend <= 1'b0;
    end else begin
      wr_pend <= accept && slv_req.write;
      rd_pend <= accept && !slv_req.write;      // clears after one wait cycle
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      dp_word <= slv_req.addr[WA+1:2];
      dp_lo   <= slv_req.addr[1:0];
      dp_size <= slv_req.size;
    end
  end

  // byte lanes from size and low address bits
  always_comb begin
    case (dp_size)
      3'd0:    be = NB'(1) << dp_lo;
      3'd1:    be = dp_lo[1] ? 4'b1100 : 4'b0011;
      default: be = '1;                          // word
    endcase
  end

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////
  always_ff @(posedge HCLK) begin
    if (wr_pend)
      for (int b = 0; b < NB; b++)
        if (be[b]) mem[dp_word][b*8 +: 8] <= slv_req.wdata[b*8 +: 8];
    if (rd_pend) rdata <= mem[dp_word];        // valid in the second cycle
  end

  assign slv_rsp.rdata = rdata;
  assign slv_rsp.ready = !rd_pend;
  assign slv_rsp.resp  = ahb_ic_pkg::RESP_OKAY;

endmodule

`default_nettype wire

// File: rtl/ahb_interconnect.sv
// AHB-Lite multi-layer interconnect top
// three master ports share two SRAM slaves, each slave reached
// through its own arbitrating slave port

`timescale 1ns/10ps
`default_nettype none

`include "ahb_ic_config.svh"

module ahb_interconnect (
  input  wire logic             HCLK,
  input  wire logic             HRESETn,
  input  ahb_ic_pkg::ahb_req_t  mst_req  [`AHB_IC_MASTERS],
  input  ahb_ic_pkg::prio_t     mst_prio [`AHB_IC_MASTERS],
  output ahb_ic_pkg::ahb_rsp_t  mst_rsp  [`AHB_IC_MASTERS]
);

  // master side view, indexed [master][slave]
  ahb_ic_pkg::ahb_req_t         m_req     [`AHB_IC_MASTERS][`AHB_IC_SLAVES];
  logic [`AHB_IC_SLAVES-1:0]    m_granted [`AHB_IC_MASTERS];
  ahb_ic_pkg::mst_vec_t         can_switch;

  // slave side view, indexed [slave][master]
  ahb_ic_pkg::ahb_req_t         s_req     [`AHB_IC_SLAVES][`AHB_IC_MASTERS];
  ahb_ic_pkg::mst_vec_t         s_granted [`AHB_IC_SLAVES];
  ahb_ic_pkg::ahb_rsp_t         s_rsp     [`AHB_IC_SLAVES];  // slave port -> all masters
  ahb_ic_pkg::ahb_req_t         sram_req  [`AHB_IC_SLAVES];
  ahb_ic_pkg::ahb_rsp_t         sram_rsp  [`AHB_IC_SLAVES];

  ////////////////////////////////////////
  // transposes
  ////////////////////////////////////////
  for (genvar m = 0; m < `AHB_IC_MASTERS; m++) begin : g_tr_m
    for (genvar s = 0; s < `AHB_IC_SLAVES; s++) begin : g_tr_s
      assign s_req[s][m]     = m_req[m][s];
      assign m_granted[m][s] = s_granted[s][m];
    end
  end

  ////////////////////////////////////////
  // master ports
  ////////////////////////////////////////
  for (genvar m = 0; m < `AHB_IC_MASTERS; m++) begin : g_mst
    ahb_master_port ahb_master_port_i (
      .HCLK       (HCLK),
      .HRESETn    (HRESETn),
      .mst_req    (mst_req[m]),
      .mst_rsp    (mst_rsp[m]),
      .req_to_slv (m_req[m]),
      .can_switch (can_switch[m]),
      .granted    (m_granted[m]),
      .slv_rsp    (s_rsp)
    );
  end

  ////////////////////////////////////////
  // slave ports and SRAMs
  ////////////////////////////////////////
  for (genvar s = 0; s < `AHB_IC_SLAVES; s++) begin : g_slv
    ahb_slave_port ahb_slave_port_i (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .mst_req        (s_req[s]),
      .mst_prio       (mst_prio),
      .can_switch     (can_switch),
      .granted_master (s_granted[s]),
      .slv_req        (sram_req[s]),
      .slv_rsp        (sram_rsp[s]),
      .mst_rsp        (s_rsp[s])
    );

    ahb_sram_slave ahb_sram_slave_i (
      .HCLK    (HCLK),
      .HRESETn (HRESETn),
      .slv_req (sram_req[s]),
      .slv_rsp (sram_rsp[s])
    );
  end

endmodule

`default_nettype wire

// File: tb/ahb_ic_props.sv
// slave port assertions for the AHB-Lite interconnect
// bound into every ahb_slave_port instance, checks the grant vector
// against the masters' requests and locks

`timescale 1ns/10ps
`default_nettype none

module ahb_ic_props (
  input wire logic              HCLK,
  input wire logic              HRESETn,
  input ahb_ic_pkg::ahb_req_t   mst_req [$bits(ahb_ic_pkg::mst_vec_t)],
  input ahb_ic_pkg::mst_vec_t   granted_master
);

  localparam int MASTERS = $bits(ahb_ic_pkg::mst_vec_t);

  ahb_ic_pkg::mst_vec_t sel_vec;   // masters selecting this slave
  ahb_ic_pkg::mst_vec_t lock_vec;  // ... with HMASTLOCK on an active transfer

  always_comb begin
    for (int m = 0; m < MASTERS; m++) begin
      sel_vec[m]  = mst_req[m].sel;
      lock_vec[m] = mst_req[m].sel && mst_req[m].mastlock;
    end
  end

  grant_onehot: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot(granted_master))
    else $error("slave port grant is not one-hot: %b", granted_master);

  // a locked owner keeps the slave
  grant_locked: assert property (@(posedge HCLK) disable iff (!HRESETn)
    |(granted_master & lock_vec) |=> $stable(granted_master))
    else $error("slave port grant moved away from a locked master");

  // a new owner is always one of the requesters
  grant_to_requester: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !$stable(granted_master) |-> |(granted_master & $past(sel_vec)))
    else $error("slave port granted a master that did not request it");

endmodule

bind ahb_slave_port ahb_ic_props ahb_ic_props_i (
  .HCLK           (HCLK),
  .HRESETn        (HRESETn),
  .mst_req        (mst_req),
  .granted_master (granted_master)
);

`default_nettype wire

// File: tb/ahb_ic_tb.sv
// testbench for the AHB-Lite multi-layer interconnect
// three bus-functional masters run directed tests on both SRAM slaves:
// sizes, unmapped access, priority, round-robin, concurrency and locking

`timescale 1ns/10ps
`default_nettype none

`include "ahb_ic_config.svh"

module ahb_ic_tb;

  localparam int NM         = `AHB_IC_MASTERS;
  localparam int RR_N       = 4;      // writes per master in the round-robin test
  localparam int MAX_CYCLES = 4000;   // all tests together need well under 1500

  logic HCLK;
  logic HRESETn;
  ahb_ic_pkg::ahb_req_t mst_req  [NM];
  ahb_ic_pkg::prio_t    mst_prio [NM];
  ahb_ic_pkg::ahb_rsp_t mst_rsp  [NM];
  int seed   = 32'h4b2f_ee6c;
  int cycles = 0;
  int rr_done [NM];                    // round-robin writes finished per master

  ahb_interconnect ahb_interconnect_i (
    .HCLK     (HCLK),
    .HRESETn  (HRESETn),
    .mst_req  (mst_req),
    .mst_prio (mst_prio),
    .mst_rsp  (mst_rsp)
  );

  initial HCLK = 1'b0;
  always #20 HCLK = ~HCLK;             // 40 ns period

  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "timeout: no test finished within %0d cycles", MAX_CYCLES);
    end
  end

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic check_data(input string test, input ahb_ic_pkg::data_t exp,
                            input ahb_ic_pkg::data_t act);
    if (act !== exp) begin
      $display("error %s: expected data %h, actual %h", test, exp, act);
      $display("TESTBENCH FAILED");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_resp(input string test, input logic exp,
                            input ahb_ic_pkg::ahb_rsp_t act);
    if (act.resp !== exp) begin
      $display("error %s: expected resp %b, actual %b", test, exp, act.resp);
      $display("TESTBENCH FAILED");
      $fatal(1, "response mismatch");
    end
  endtask

  // equal levels rotate, so no master gets two writes ahead of another
  task automatic check_fair(input int m);
    for (int n = 0; n < NM; n++)
      if (rr_done[m] > rr_done[n] + 1) begin
        $display("error round_robin: master %0d finished %0d writes while master %0d had %0d",
                 m, rr_done[m], n, rr_done[n]);
        $display("TESTBENCH FAILED");
        $fatal(1, "round-robin arbitration let one master get ahead");
      end
  endtask

  // byte lanes written for a given size and low address bits
  function automatic ahb_ic_pkg::data_t lane_merge(input ahb_ic_pkg::data_t old,
    input ahb_ic_pkg::data_t wd, input ahb_ic_pkg::addr_t addr, input logic [2:0] size);
    ahb_ic_pkg::data_t res;
    res = old;
    for (int b = 0; b < 4; b++)
      if ((size == 3'd0 && b == int'(addr[1:0])) ||
          (size == 3'd1 && b / 2 == int'(addr[1])) || size >= 3'd2)
        res[b*8 +: 8] = wd[b*8 +: 8];
    return res;
  endfunction

  ////////////////////////////////////////
  // master bus-functional tasks
  ////////////////////////////////////////
  // called 2 ns after an edge, returns 2 ns after the completing edge
  task automatic wait_ready(input int m, output ahb_ic_pkg::ahb_rsp_t rsp);
    @(negedge HCLK);
    while (!mst_rsp[m].ready) @(negedge HCLK);   // mid-cycle, outputs settled
    rsp = mst_rsp[m];
    @(posedge HCLK);
    #2;
  endtask

  task automatic bus_xfer(input int m, input logic write, input ahb_ic_pkg::addr_t addr,
    input logic [2:0] size, input ahb_ic_pkg::data_t wd, input logic lock,
    output ahb_ic_pkg::ahb_rsp_t rsp);
    mst_req[m].sel      = 1'b1;
    mst_req[m].addr     = addr;
    mst_req[m].write    = write;
    mst_req[m].size     = size;
    mst_req[m].trans    = ahb_ic_pkg::NONSEQ;
    mst_req[m].mastlock = lock;
    wait_ready(m, rsp);                          // address phase
    mst_req[m].sel   = 1'b0;
    mst_req[m].trans = ahb_ic_pkg::IDLE;         // lock stays up with the data phase
    mst_req[m].wdata = write ? wd : '0;
    wait_ready(m, rsp);                          // data phase
  endtask

  task automatic ahb_write(input int m, input ahb_ic_pkg::addr_t addr, input logic [2:0] size,
    input ahb_ic_pkg::data_t wd, input logic lock, output ahb_ic_pkg::ahb_rsp_t rsp);
    bus_xfer(m, 1'b1, addr, size, wd, lock, rsp);
  endtask

  task automatic ahb_read(input int m, input ahb_ic_pkg::addr_t addr, input logic [2:0] size,
    input logic lock, output ahb_ic_pkg::ahb_rsp_t rsp);
    bus_xfer(m, 1'b0, addr, size, '0, lock, rsp);
  endtask

  task automatic write_read(input int m, input string test, input ahb_ic_pkg::addr_t addr,
    input ahb_ic_pkg::data_t wd);
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_write(m, addr, 3'd2, wd, 1'b0, rsp);
    check_resp(test, ahb_ic_pkg::RESP_OKAY, rsp);
    ahb_read(m, addr, 3'd2, 1'b0, rsp);
    check_resp(test, ahb_ic_pkg::RESP_OKAY, rsp);
    check_data(test, wd, rsp.rdata);
  endtask

  task automatic write_repeat(input int m, input ahb_ic_pkg::addr_t addr,
    output ahb_ic_pkg::data_t last);
    ahb_ic_pkg::ahb_rsp_t rsp;
    for (int i = 0; i < RR_N; i++) begin
      last = {8'(m), 8'(i), 16'h5a5a};           // distinct per master and pass
      ahb_write(m, addr, 3'd2, last, 1'b0, rsp);
      check_resp("round_robin", ahb_ic_pkg::RESP_OKAY, rsp);
      rr_done[m]++;
      check_fair(m);
    end
  endtask

  task automatic locked_write_read(input int m, input ahb_ic_pkg::addr_t addr,
    input ahb_ic_pkg::data_t wd, output ahb_ic_pkg::data_t rd);
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_write(m, addr, 3'd2, wd, 1'b1, rsp);
    check_resp("locked", ahb_ic_pkg::RESP_OKAY, rsp);
    ahb_read(m, addr, 3'd2, 1'b1, rsp);
    mst_req[m].mastlock = 1'b0;                  // sequence over
    rd = rsp.rdata;
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_sizes();
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_ic_pkg::data_t    exp;
    ahb_ic_pkg::data_t    wd;
    ahb_ic_pkg::addr_t    base;
    for (int s = 0; s < 2; s++) begin
      base = (s == 0) ? `AHB_IC_SLV_BASE0 + 32'h40 : `AHB_IC_SLV_BASE1 + 32'h7c;
      wd = $random(seed);
      ahb_write(1, base, 3'd2, wd, 1'b0, rsp);
      exp = wd;
      wd = $random(seed);
      ahb_write(1, base + 2, 3'd1, wd, 1'b0, rsp);   // upper halfword
      exp = lane_merge(exp, wd, base + 2, 3'd1);
      wd = $random(seed);
      ahb_write(1, base + 1, 3'd0, wd, 1'b0, rsp);   // byte 1
      exp = lane_merge(exp, wd, base + 1, 3'd0);
      check_resp("sizes", ahb_ic_pkg::RESP_OKAY, rsp);
      ahb_read(1, base, 3'd2, 1'b0, rsp);
      check_resp("sizes", ahb_ic_pkg::RESP_OKAY, rsp);
      check_data("sizes", exp, rsp.rdata);
    end
  endtask

  task automatic test_unmapped();
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_write(0, 32'h0000_3000, 3'd2, 32'hdead_beef, 1'b0, rsp);
    check_resp("unmapped", ahb_ic_pkg::RESP_ERROR, rsp);
    ahb_read(0, 32'h0000_2004, 3'd2, 1'b0, rsp);
    check_resp("unmapped", ahb_ic_pkg::RESP_ERROR, rsp);
    write_read(0, "unmapped", `AHB_IC_SLV_BASE0 + 32'h80, $random(seed));
  endtask

  task automatic test_priority();
    ahb_ic_pkg::ahb_rsp_t rsp0;
    ahb_ic_pkg::ahb_rsp_t rsp2;
    ahb_ic_pkg::data_t    v0;
    ahb_ic_pkg::data_t    v2;
    ahb_ic_pkg::addr_t    a;
    a = `AHB_IC_SLV_BASE1 + 32'h200;
    mst_prio[0] = 3'd1;
    mst_prio[2] = 3'd5;
    ahb_write(1, a + 4, 3'd2, 32'h0, 1'b0, rsp2);    // leaves slave 1 with a bystander
    v0 = $random(seed);
    v2 = ~v0;
    fork
      ahb_write(0, a, 3'd2, v0, 1'b0, rsp0);
      ahb_write(2, a, 3'd2, v2, 1'b0, rsp2);
    join
    check_resp("priority", ahb_ic_pkg::RESP_OKAY, rsp0);
    check_resp("priority", ahb_ic_pkg::RESP_OKAY, rsp2);
    // higher level goes first, the lower one overwrites it
    ahb_read(1, a, 3'd2, 1'b0, rsp0);
    check_data("priority", (mst_prio[0] > mst_prio[2]) ? v2 : v0, rsp0.rdata);
  endtask

  task automatic test_round_robin();
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_ic_pkg::data_t    last [NM];
    for (int m = 0; m < NM; m++) begin
      mst_prio[m] = 3'd3;
      rr_done[m]  = 0;
    end
    fork
      write_repeat(0, `AHB_IC_SLV_BASE0 + 32'h100, last[0]);
      write_repeat(1, `AHB_IC_SLV_BASE0 + 32'h104, last[1]);
      write_repeat(2, `AHB_IC_SLV_BASE0 + 32'h108, last[2]);
    join
    for (int m = 0; m < NM; m++) begin
      ahb_read((m + 1) % NM, `AHB_IC_SLV_BASE0 + 32'h100 + 32'(4 * m), 3'd2, 1'b0, rsp);
      check_data("round_robin", last[m], rsp.rdata);
    end
  endtask

  task automatic test_concurrent();
    ahb_ic_pkg::data_t v [NM];
    for (int m = 0; m < NM; m++) v[m] = $random(seed);
    fork
      write_read(0, "concurrent", `AHB_IC_SLV_BASE0 + 32'h300, v[0]);
      write_read(1, "concurrent", `AHB_IC_SLV_BASE1 + 32'h300, v[1]);
      write_read(2, "concurrent", `AHB_IC_SLV_BASE1 + 32'h304, v[2]);
    join
  endtask

  task automatic test_locked();
    ahb_ic_pkg::ahb_rsp_t rsp;
    ahb_ic_pkg::data_t    v0;
    ahb_ic_pkg::data_t    v1;
    ahb_ic_pkg::data_t    rd;
    mst_prio[0] = 3'd6;                          // the intruder outranks the locked master
    mst_prio[1] = 3'd2;
    ahb_read(1, `AHB_IC_SLV_BASE0 + 32'h3c4, 3'd2, 1'b0, rsp);  // slave 0 starts with master 1
    v1 = $random(seed);
    v0 = ~v1;
    fork
      locked_write_read(1, `AHB_IC_SLV_BASE0 + 32'h3c0, v1, rd);
      ahb_write(0, `AHB_IC_SLV_BASE0 + 32'h3c0, 3'd2, v0, 1'b0, rsp);
    join
    check_resp("locked", ahb_ic_pkg::RESP_OKAY, rsp);
    check_data("locked", v1, rd);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial begin
    HRESETn = 1'b0;
    for (int m = 0; m < NM; m++) begin
      mst_req[m]       = '0;                     // IDLE, no select
      mst_req[m].ready = 1'b1;
      mst_prio[m]      = '0;
    end
    repeat (8) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    test_sizes();
    test_unmapped();
    test_priority();
    test_round_robin();
    test_concurrent();
    test_locked();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+rtl
rtl/ahb_ic_pkg.sv
rtl/ahb_master_port.sv
rtl/ahb_slave_port.sv
rtl/ahb_sram_slave.sv
rtl/ahb_interconnect.sv
tb/ahb_ic_props.sv
tb/ahb_ic_tb.sv

// File: Makefile
# Verilator flow for the AHB-Lite interconnect testbench
# a failing run ends in $fatal, which gives a nonzero exit status

TOP = ahb_ic_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
